// ==== build.f ====
+incdir+.
renamePkg.sv
renameLogicIF.sv
renameMapTable.sv
activeList.sv
renameSerializer.sv
renameStage.sv
renameCore.sv
tb_renameCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the rename core testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_renameCore -f build.f -o tb_renameCore

# A failing check ends in $fatal, so the exit status carries the result
./obj_dir/tb_renameCore

// ==== renameVectors.txt ====
# vOp0 vOp1 | srcA0 srcB0 dst0 wr0 | srcA1 srcB1 dst1 wr1 | serialized holdCommit
# then expected phySrcA phySrcB phyDst phyPrevDst for slot 0 and slot 1, all hex
1 1 1 2 3 1 3 0 4 1 0 0 1 2 8 3 8 0 9 4
1 1 3 4 3 1 3 3 3 1 0 0 8 9 a 8 a a b a
1 0 3 5 5 1 0 0 0 0 0 0 b 5 c 5 0 0 0 0
1 1 5 4 0 0 0 5 6 1 0 0 c 9 0 0 0 c d 6
1 0 6 3 7 1 0 0 0 0 1 0 d b e 7 0 0 0 0
1 1 7 1 1 1 1 2 2 1 0 1 e 1 f 1 f 2 3 2
1 1 2 0 0 1 0 1 5 1 0 0 3 0 4 0 4 f 8 c
1 1 5 5 6 1 6 7 7 1 0 0 8 8 a d a e 5 e
1 1 0 1 3 1 2 3 4 1 0 0 4 f 6 b 3 6 7 9
1 1 3 4 1 1 1 0 0 0 0 0 6 7 1 f 1 4 0 0
1 1 1 7 2 1 2 2 2 1 0 0 1 5 2 3 2 2 0 2
1 0 2 6 0 0 0 0 0 0 1 0 0 a 0 0 0 0 0 0
1 1 0 2 6 1 6 5 7 1 0 0 4 0 c a c 8 d 5

// ==== tb_renameCore.sv ====
/*
 Testbench for the rename core. Groups and expected registers come from renameVectors.txt.
 Destinations are compared only for ops that write a register.
 A holdCommit group keeps commit low after it renames until the active list has been full.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

module tb_renameCore;

    localparam int maxGroups = 32;
    localparam int cyclesPerGroup = 64;
    localparam int fullHoldCycles = 6;

    logic clk = 1'b0;
    logic rst;
    logic opValid [`RN_WIDTH];
    renamePkg::LogRegNum opSrcA [`RN_WIDTH];
    renamePkg::LogRegNum opSrcB [`RN_WIDTH];
    renamePkg::LogRegNum opDst [`RN_WIDTH];
    logic opWriteReg [`RN_WIDTH];
    logic opSerialized;
    logic commit;
    logic stallUpper;
    logic outValid [`RN_WIDTH];
    renamePkg::PhyRegNum outPhySrcA [`RN_WIDTH];
    renamePkg::PhyRegNum outPhySrcB [`RN_WIDTH];
    renamePkg::PhyRegNum outPhyDst [`RN_WIDTH];
    renamePkg::PhyRegNum outPhyPrevDst [`RN_WIDTH];
    renamePkg::ActiveListPtr outActiveListPtr [`RN_WIDTH];
    renamePkg::ActiveListCount activeListCount;

    // One hex digit per field of a vector line
    logic [3:0] vec [maxGroups][20];
    int numGroups = 0;
    int drvIdx = 0;
    int chkIdx = 0;
    int ptrModel = 0;
    int fullCycles = 0;
    int cycleCount = 0;
    int cycleLimit = maxGroups * cyclesPerGroup;
    logic [31:0] lfsr = 32'h9bf54ac8;
    logic captured = 1'b0;
    logic holdActive = 1'b0;
    logic fillSeen = 1'b0;
    logic serWait = 1'b0;

    renameCore i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopRun($sformatf("Timeout after %0d cycles with %0d groups renamed",
                cycleCount, chkIdx));
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic checkValue(input string name, input int got, input int want);
        assert (got == want) else begin
            stopRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    task automatic checkSlot(input string field, input int i, input int got, input int want);
        checkValue($sformatf("group %0d %s[%0d]", chkIdx, field, i), got, want);
    endtask

    task automatic driveGroup(input int n);
        for (int i = 0; i < `RN_WIDTH; i++) begin
            opValid[i] = vec[n][i][0];
            opSrcA[i] = vec[n][2 + 4 * i][2:0];
            opSrcB[i] = vec[n][3 + 4 * i][2:0];
            opDst[i] = vec[n][4 + 4 * i][2:0];
            opWriteReg[i] = vec[n][5 + 4 * i][0];
        end
        opSerialized = vec[n][10][0];
    endtask

    task automatic driveIdle();
        for (int i = 0; i < `RN_WIDTH; i++) begin
            opValid[i] = 1'b0;
            opSrcA[i] = '0;
            opSrcB[i] = '0;
            opDst[i] = '0;
            opWriteReg[i] = 1'b0;
        end
        opSerialized = 1'b0;
    endtask

    // Sampled mid-cycle once inputs and registers have settled
    task automatic checkCycle();
        logic anyValid;
        anyValid = outValid[0] || outValid[1];
        captured = !stallUpper;
        assert (int'(activeListCount) <= `RN_AL_DEPTH) else begin
            stopRun("Active list count went above its depth");
        end
        if (int'(activeListCount) == `RN_AL_DEPTH) begin
            assert (!anyValid) else stopRun("A group renamed while the active list was full");
            if (holdActive) begin
                assert (stallUpper) else stopRun("stallUpper low while the active list was full");
                fillSeen = 1'b1;
                fullCycles++;
                if (fullCycles == fullHoldCycles) begin
                    holdActive = 1'b0;
                end
            end
        end
        if (serWait && activeListCount == '0) begin
            serWait = 1'b0;
        end
        if (anyValid) begin
            assert (!serWait) else stopRun("A group renamed before the serialized op committed");
            for (int i = 0; i < `RN_WIDTH; i++) begin
                checkSlot("outValid", i, int'(outValid[i]), int'(vec[chkIdx][i]));
                if (outValid[i]) begin
                    checkSlot("outPhySrcA", i, int'(outPhySrcA[i]), int'(vec[chkIdx][12 + 4 * i]));
                    checkSlot("outPhySrcB", i, int'(outPhySrcB[i]), int'(vec[chkIdx][13 + 4 * i]));
                    if (vec[chkIdx][5 + 4 * i][0]) begin
                        checkSlot("outPhyDst", i, int'(outPhyDst[i]),
                            int'(vec[chkIdx][14 + 4 * i]));
                        checkSlot("outPhyPrevDst", i, int'(outPhyPrevDst[i]),
                            int'(vec[chkIdx][15 + 4 * i]));
                    end
                    // Slots follow program order and wrap at the list depth
                    checkSlot("outActiveListPtr", i, int'(outActiveListPtr[i]),
                        ptrModel % `RN_AL_DEPTH);
                    ptrModel++;
                end
            end
            if (vec[chkIdx][10][0]) begin
                checkSlot("activeListCount", 0, int'(activeListCount), 0);
                serWait = 1'b1;
            end
            if (vec[chkIdx][11][0]) begin
                holdActive = 1'b1;
                fullCycles = 0;
            end
            chkIdx++;
        end
    endtask

    initial begin
        int fd;
        int got;
        string line;
        logic [3:0] fld [20];
        rst = 1'b1;
        commit = 1'b0;
        driveIdle();
        fd = $fopen("renameVectors.txt", "r");
        assert (fd != 0) else stopRun("Could not open renameVectors.txt");
        while (!$feof(fd) && numGroups < maxGroups) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                    fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                    fld[17], fld[18], fld[19]);
                assert (got == 20) else stopRun("Malformed line in renameVectors.txt");
                for (int k = 0; k < 20; k++) begin
                    vec[numGroups][k] = fld[k];
                end
                numGroups++;
            end
        end
        $fclose(fd);
        assert (numGroups > 0) else stopRun("No groups found in renameVectors.txt");
        cycleLimit = numGroups * cyclesPerGroup;

        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;
        driveGroup(0);
        @(negedge clk);
        checkValue("stallUpper after reset", int'(stallUpper), 0);
        checkValue("activeListCount after reset", int'(activeListCount), 0);
        for (int i = 0; i < `RN_WIDTH; i++) begin
            checkValue($sformatf("outValid[%0d] after reset", i), int'(outValid[i]), 0);
        end
        captured = !stallUpper;

        while (chkIdx < numGroups) begin
            @(posedge clk);
            #0.5;
            if (captured) begin
                drvIdx++;
                if (drvIdx < numGroups) begin
                    driveGroup(drvIdx);
                end else begin
                    driveIdle();
                end
            end
            if (holdActive) begin
                commit = 1'b0;
            end else begin
                lfsr = lfsrStep(lfsr);
                commit = lfsr[0];
            end
            @(negedge clk);
            checkCycle();
        end

        if (!fillSeen) begin
            $display("The active list never filled while commit was held low");
            $display("TEST FAILED");
            $fatal(1, "Active list fill not observed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== renameCore.sv ====
/*
 Two-wide register rename top level with plain ports.
 No flush or branch recovery. Upstream holds its inputs while stallUpper is high.
 commit retires one op per cycle and is ignored while the active list is empty.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

module renameCore (
    input logic clk,
    input logic rst,
    input logic opValid [`RN_WIDTH],
    input renamePkg::LogRegNum opSrcA [`RN_WIDTH],
    input renamePkg::LogRegNum opSrcB [`RN_WIDTH],
    input renamePkg::LogRegNum opDst [`RN_WIDTH],
    input logic opWriteReg [`RN_WIDTH],
    input logic opSerialized,
    input logic commit,
    output logic stallUpper,
    output logic outValid [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhySrcA [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhySrcB [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhyDst [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhyPrevDst [`RN_WIDTH],
    output renamePkg::ActiveListPtr outActiveListPtr [`RN_WIDTH],
    output renamePkg::ActiveListCount activeListCount
);

    renameLogicIF rl ();

    logic alPush [`RN_WIDTH];
    renamePkg::ActiveListEntry alEntry [`RN_WIDTH];
    renamePkg::ActiveListPtr alPushedPtr [`RN_WIDTH];
    logic alCommit;
    renamePkg::ActiveListEntry alHeadEntry;

    renameStage i_stage (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opSrcA(opSrcA),
        .opSrcB(opSrcB),
        .opDst(opDst),
        .opWriteReg(opWriteReg),
        .opSerialized(opSerialized),
        .commit(commit),
        .rl(rl),
        .alPush(alPush),
        .alEntry(alEntry),
        .alPushedPtr(alPushedPtr),
        .alCount(activeListCount),
        .alCommit(alCommit),
        .alHeadEntry(alHeadEntry),
        .stallUpper(stallUpper),
        .outValid(outValid),
        .outPhySrcA(outPhySrcA),
        .outPhySrcB(outPhySrcB),
        .outPhyDst(outPhyDst),
        .outPhyPrevDst(outPhyPrevDst),
        .outActiveListPtr(outActiveListPtr)
    );

    renameMapTable i_mapTable (
        .clk(clk),
        .rst(rst),
        .rl(rl)
    );

    activeList i_activeList (
        .clk(clk),
        .rst(rst),
        .push(alPush),
        .entry(alEntry),
        .pushedPtr(alPushedPtr),
        .commit(alCommit),
        .headEntry(alHeadEntry),
        .count(activeListCount)
    );

endmodule

// ==== renameStage.sv ====
/*
 Rename stage. Holds one group and renames it when all resources are available.
 Results are combinational from the held group; outValid marks the renaming cycle.
 A serializing op is expected alone in slot 0.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

module renameStage (
    input logic clk,
    input logic rst,
    input logic opValid [`RN_WIDTH],
    input renamePkg::LogRegNum opSrcA [`RN_WIDTH],
    input renamePkg::LogRegNum opSrcB [`RN_WIDTH],
    input renamePkg::LogRegNum opDst [`RN_WIDTH],
    input logic opWriteReg [`RN_WIDTH],
    input logic opSerialized,
    input logic commit,
    renameLogicIF.stage rl,
    output logic alPush [`RN_WIDTH],
    output renamePkg::ActiveListEntry alEntry [`RN_WIDTH],
    input renamePkg::ActiveListPtr alPushedPtr [`RN_WIDTH],
    input renamePkg::ActiveListCount alCount,
    output logic alCommit,
    input renamePkg::ActiveListEntry alHeadEntry,
    output logic stallUpper,
    output logic outValid [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhySrcA [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhySrcB [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhyDst [`RN_WIDTH],
    output renamePkg::PhyRegNum outPhyPrevDst [`RN_WIDTH],
    output renamePkg::ActiveListPtr outActiveListPtr [`RN_WIDTH]
);

    // Held group
    logic regValid [`RN_WIDTH];
    renamePkg::LogRegNum regSrcA [`RN_WIDTH];
    renamePkg::LogRegNum regSrcB [`RN_WIDTH];
    renamePkg::LogRegNum regDst [`RN_WIDTH];
    logic regWriteReg [`RN_WIDTH];
    logic regSerialized;

    logic update [`RN_WIDTH];
    renamePkg::ActiveListCount alNeed;
    logic groupValid;
    logic alRoom;
    logic resourceStall;
    logic serialize;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                regValid[i] <= 1'b0;
            end
        end else if (!stallUpper) begin
            regValid <= opValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallUpper) begin
            regSrcA <= opSrcA;
            regSrcB <= opSrcB;
            regDst <= opDst;
            regWriteReg <= opWriteReg;
            regSerialized <= opSerialized;
        end
    end

    // Back-pressure uses only held state, never update
    always_comb begin
        alNeed = '0;
        groupValid = 1'b0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (regValid[i]) begin
                alNeed = alNeed + 1'b1;
                groupValid = 1'b1;
            end
        end
        alRoom = (alCount + alNeed) <= renamePkg::ActiveListCount'(`RN_AL_DEPTH);
        resourceStall = groupValid && (!rl.allocatable || !alRoom);
        stallUpper = resourceStall || serialize;
    end

    renameSerializer i_serializer (
        .clk(clk),
        .rst(rst),
        .stall(resourceStall),
        .activeListEmpty(alCount == '0),
        .serialized(regSerialized),
        .valid(regValid[0]),
        .serialize(serialize)
    );

    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            update[i] = regValid[i] && !stallUpper;
            rl.update[i] = update[i];
            rl.logSrcA[i] = regSrcA[i];
            rl.logSrcB[i] = regSrcB[i];
            rl.logDst[i] = regDst[i];
            rl.writeReg[i] = regValid[i] && regWriteReg[i];

            alPush[i] = update[i];
            alEntry[i].logDst = regDst[i];
            alEntry[i].phyDst = rl.phyDst[i];
            alEntry[i].phyPrevDst = rl.phyPrevDst[i];
            alEntry[i].writeReg = regWriteReg[i];

            outValid[i] = update[i];
            outPhySrcA[i] = rl.phySrcA[i];
            outPhySrcB[i] = rl.phySrcB[i];
            outPhyDst[i] = rl.phyDst[i];
            outPhyPrevDst[i] = rl.phyPrevDst[i];
            outActiveListPtr[i] = alPushedPtr[i];
        end

        // Retire the head, its old mapping goes back to the free list
        alCommit = commit && (alCount != '0);
        rl.freeValid = alCommit && alHeadEntry.writeReg;
        rl.freeReg = alHeadEntry.phyPrevDst;
    end

endmodule

// ==== renameSerializer.sv ====
/*
 Holds the rename stage around a serializing op in slot 0.
 Assumes a serializing op always arrives alone in its group.
*/
`timescale 1ns/1ps

module renameSerializer (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic activeListEmpty,
    input logic serialized,
    input logic valid,
    output logic serialize
);

    typedef enum logic {
        phaseNormal,
        // Own op renamed, waiting for it to commit
        phaseWaitOwn
    } SerialPhase;

    SerialPhase phase;
    SerialPhase nextPhase;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phaseNormal;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        serialize = 1'b0;
        nextPhase = phaseNormal;
        if (phase == phaseNormal) begin
            if (serialized && valid) begin
                // Older ops drain first, then the op renames alone
                serialize = !activeListEmpty;
                nextPhase = activeListEmpty ? phaseWaitOwn : phaseNormal;
            end
        end else begin
            serialize = !activeListEmpty;
            nextPhase = activeListEmpty ? phaseNormal : phaseWaitOwn;
        end
    end

endmodule

// ==== activeList.sv ====
/*
 In-order queue of renamed ops.
 Callers push only when there is room and commit only when count is nonzero.
 Pushes and the commit pop both show in count at the next edge.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

module activeList (
    input logic clk,
    input logic rst,
    input logic push [`RN_WIDTH],
    input renamePkg::ActiveListEntry entry [`RN_WIDTH],
    output renamePkg::ActiveListPtr pushedPtr [`RN_WIDTH],
    input logic commit,
    output renamePkg::ActiveListEntry headEntry,
    output renamePkg::ActiveListCount count
);

    renamePkg::ActiveListEntry entries [`RN_AL_DEPTH];
    renamePkg::ActiveListPtr head;
    renamePkg::ActiveListPtr tail;
    renamePkg::ActiveListCount pushCount;

    // Each pushing slot lands right after the older pushing slots
    always_comb begin
        pushCount = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            pushedPtr[i] = tail + renamePkg::ActiveListPtr'(pushCount);
            if (push[i]) begin
                pushCount = pushCount + 1'b1;
            end
        end
        headEntry = entries[head];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (push[i]) begin
                entries[pushedPtr[i]] <= entry[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            tail <= tail + renamePkg::ActiveListPtr'(pushCount);
            if (commit) begin
                head <= head + 1'b1;
            end
            count <= count + pushCount - renamePkg::ActiveListCount'(commit);
        end
    end

endmodule

// ==== renameMapTable.sv ====
/*
 Register map table with a free-list FIFO.
 New destinations are taken in FIFO order, one per writing slot.
 The free list never overflows, since at most RN_PHY_REGS - RN_LOG_REGS are free.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

module renameMapTable (
    input logic clk,
    input logic rst,
    renameLogicIF.mapTable rl
);

    localparam int freeIdxBits = $clog2(`RN_PHY_REGS);
    localparam int initFreeRegs = `RN_PHY_REGS - `RN_LOG_REGS;

    renamePkg::PhyRegNum regMap [`RN_LOG_REGS];
    renamePkg::PhyRegNum freeList [`RN_PHY_REGS];
    logic [freeIdxBits-1:0] freeHead;
    logic [freeIdxBits-1:0] freeTail;
    logic [freeIdxBits:0] freeCount;

    logic [freeIdxBits-1:0] allocIdx;
    logic [freeIdxBits:0] need;
    logic [freeIdxBits:0] popCount;

    always_comb begin
        allocIdx = freeHead;
        need = '0;
        popCount = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            rl.phyDst[i] = freeList[allocIdx];
            rl.phySrcA[i] = regMap[rl.logSrcA[i]];
            rl.phySrcB[i] = regMap[rl.logSrcB[i]];
            rl.phyPrevDst[i] = regMap[rl.logDst[i]];

            // Older slots in the group override the table, youngest writer last
            for (int j = 0; j < i; j++) begin
                if (rl.writeReg[j] && rl.logDst[j] == rl.logSrcA[i]) begin
                    rl.phySrcA[i] = rl.phyDst[j];
                end
                if (rl.writeReg[j] && rl.logDst[j] == rl.logSrcB[i]) begin
                    rl.phySrcB[i] = rl.phyDst[j];
                end
                if (rl.writeReg[j] && rl.logDst[j] == rl.logDst[i]) begin
                    rl.phyPrevDst[i] = rl.phyDst[j];
                end
            end

            if (rl.writeReg[i]) begin
                allocIdx = allocIdx + 1'b1;
                need = need + 1'b1;
            end
            if (rl.update[i] && rl.writeReg[i]) begin
                popCount = popCount + 1'b1;
            end
        end
        rl.allocatable = freeCount >= need;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_LOG_REGS; i++) begin
                regMap[i] <= renamePkg::PhyRegNum'(i);
            end
            // Registers above the identity-mapped ones start out free
            for (int i = 0; i < `RN_PHY_REGS; i++) begin
                freeList[i] <= renamePkg::PhyRegNum'(`RN_LOG_REGS + i);
            end
            freeHead <= '0;
            freeTail <= (freeIdxBits)'(initFreeRegs);
            freeCount <= (freeIdxBits + 1)'(initFreeRegs);
        end else begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (rl.update[i] && rl.writeReg[i]) begin
                    regMap[rl.logDst[i]] <= rl.phyDst[i];
                end
            end
            if (rl.freeValid) begin
                freeList[freeTail] <= rl.freeReg;
                freeTail <= freeTail + 1'b1;
            end
            freeHead <= freeHead + popCount[freeIdxBits-1:0];
            freeCount <= freeCount + (freeIdxBits + 1)'(rl.freeValid) - popCount;
        end
    end

endmodule

// ==== renameLogicIF.sv ====
/*
 Link between the rename stage and the map table.
 writeReg is expected to be qualified with the slot's valid bit.
 The map table outputs are combinational from the request signals.
*/
`timescale 1ns/1ps
`include "renameCore_settings.svh"

interface renameLogicIF;

    // Requests per slot
    renamePkg::LogRegNum logSrcA [`RN_WIDTH];
    renamePkg::LogRegNum logSrcB [`RN_WIDTH];
    renamePkg::LogRegNum logDst [`RN_WIDTH];
    logic writeReg [`RN_WIDTH];
    logic update [`RN_WIDTH];

    // Renamed results per slot
    renamePkg::PhyRegNum phySrcA [`RN_WIDTH];
    renamePkg::PhyRegNum phySrcB [`RN_WIDTH];
    renamePkg::PhyRegNum phyDst [`RN_WIDTH];
    renamePkg::PhyRegNum phyPrevDst [`RN_WIDTH];
    logic allocatable;

    // Register freed by commit
    logic freeValid;
    renamePkg::PhyRegNum freeReg;

    modport stage (
        output logSrcA, logSrcB, logDst, writeReg, update, freeValid, freeReg,
        input phySrcA, phySrcB, phyDst, phyPrevDst, allocatable
    );

    modport mapTable (
        input logSrcA, logSrcB, logDst, writeReg, update, freeValid, freeReg,
        output phySrcA, phySrcB, phyDst, phyPrevDst, allocatable
    );

endinterface

// ==== renamePkg.sv ====
/*
 Types shared by the rename stage, the map table and the active list.
 Widths follow the sizes in the settings header.
*/
`include "renameCore_settings.svh"

package renamePkg;

    // Architectural register number
    typedef logic [$clog2(`RN_LOG_REGS)-1:0] LogRegNum;

    // Physical register number
    typedef logic [$clog2(`RN_PHY_REGS)-1:0] PhyRegNum;

    // Index into the active list
    typedef logic [$clog2(`RN_AL_DEPTH)-1:0] ActiveListPtr;

    // One extra bit so a full list reads as RN_AL_DEPTH
    typedef logic [$clog2(`RN_AL_DEPTH):0] ActiveListCount;

    // One renamed op waiting for commit
    typedef struct packed {
        LogRegNum logDst;
        PhyRegNum phyDst;
        // Goes back to the free list when this entry retires
        PhyRegNum phyPrevDst;
        logic writeReg;
    } ActiveListEntry;

endpackage

// ==== renameCore_settings.svh ====
/*
 Sizes of the rename subsystem. RN_PHY_REGS and RN_AL_DEPTH must be powers of two.
 RN_PHY_REGS must exceed RN_LOG_REGS so that the free list starts non-empty.
*/
`ifndef RENAMECORE_SETTINGS_SVH
`define RENAMECORE_SETTINGS_SVH

// Ops renamed per group
`define RN_WIDTH 2

// Architectural registers
`define RN_LOG_REGS 8

// Physical registers, the low ones identity mapped after reset
`define RN_PHY_REGS 16
`define RN_AL_DEPTH 8

`endif
